// File: source/calc_defines.svh
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// operand and result width
`define CALC_WORD_W        32

// tokens per region (infix, postfix)
`define CALC_QUEUE_DEPTH   16

// operator stack and value stack
`define CALC_STACK_DEPTH   8

// token memory covers both regions
`define CALC_ADDR_W        5
`define CALC_POSTFIX_BASE  16

// operands in one expression
`define CALC_MAX_OPERANDS  8

`endif

// File: source/calc_pkg.sv
`default_nettype none

`include "calc_defines.svh"

package calc_pkg;

    // digit keys carry their value in the low nibble
    typedef enum logic [4:0] {
        KEY_0 = 5'd0, KEY_1, KEY_2, KEY_3, KEY_4,
        KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
        KEY_ADD,
        KEY_SUB,
        KEY_MUL,
        KEY_NEG,
        KEY_EQU,
        KEY_CLR
    } key_e;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } opcode_e;

    typedef enum logic {
        TOK_NUM,
        TOK_OP
    } tok_kind_e;

    typedef logic signed [`CALC_WORD_W-1:0] word_t;

    typedef struct packed {
        tok_kind_e kind;
        opcode_e   op;     // valid for TOK_OP
        word_t     value;  // valid for TOK_NUM
    } token_t;

endpackage

`default_nettype wire

// File: source/token_mem_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

// one client's port into the shared token memory
interface token_mem_if
    import calc_pkg::*;
;
    logic                    req;
    logic                    we;
    logic [`CALC_ADDR_W-1:0] addr;
    token_t                  wdata;

    logic                    gnt;   // access happens on this edge
    token_t                  rdata; // valid the cycle after gnt

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

// File: source/token_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

module token_arbiter
    import calc_pkg::*;
(
    input wire logic     rst,
    input wire logic     clk_100hz,
    token_mem_if.arbiter ent,
    token_mem_if.arbiter cnv,
    token_mem_if.arbiter evl
);

    // infix region at 0, postfix region at CALC_POSTFIX_BASE
    token_t mem [0:(1 << `CALC_ADDR_W)-1];

    logic                    sel_we;
    logic [`CALC_ADDR_W-1:0] sel_addr;
    token_t                  sel_wdata;
    token_t                  rd_q;

    // evaluator wins, then converter, then entry
    assign evl.gnt = evl.req;
    assign cnv.gnt = cnv.req && !evl.req;
    assign ent.gnt = ent.req && !evl.req && !cnv.req;

    always_comb
    begin
        if (evl.req)
        begin
            sel_we    = evl.we;
            sel_addr  = evl.addr;
            sel_wdata = evl.wdata;
        end
        else if (cnv.req)
        begin
            sel_we    = cnv.we;
            sel_addr  = cnv.addr;
            sel_wdata = cnv.wdata;
        end
        else
        begin
            sel_we    = ent.req && ent.we; // idle when nobody asks
            sel_addr  = ent.addr;
            sel_wdata = ent.wdata;
        end
    end

    always_ff @(posedge rst)
    begin
        if (sel_we)
            mem[sel_addr] <= sel_wdata;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            rd_q <= '0;
        else
            rd_q <= mem[sel_addr];
    end

    // only the client granted last cycle looks at it
    assign ent.rdata = rd_q;
    assign cnv.rdata = rd_q;
    assign evl.rdata = rd_q;

endmodule

`default_nettype wire

// File: source/expr_entry.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

module expr_entry
    import calc_pkg::*;
(
    input  wire logic               rst,
    input  wire logic               clk_100hz,
    input  wire logic               key_valid,
    input  wire key_e               key_code,
    input  wire logic               eval_done,
    token_mem_if.client             mem,
    output logic                    expr_start,
    output logic [`CALC_ADDR_W-1:0] infix_count,
    output logic                    busy
);

    localparam int CNT_W = $clog2(`CALC_MAX_OPERANDS + 1);

    word_t                   mag;
    logic                    neg;
    logic                    have_digit;
    logic [CNT_W-1:0]        opnd_cnt;   // operands already written
    logic [`CALC_ADDR_W-1:0] wr_ptr;
    logic                    num_pend;
    logic                    op_pend;
    logic                    eq_pend;
    logic                    busy_q;
    word_t                   num_val;
    opcode_e                 op_val;
    logic                    accept;
    logic                    room;

    // low already in the cycle result_valid shows up
    assign busy = busy_q && !eval_done;

    assign accept = key_valid && !busy && !num_pend && !op_pend;

    // the operand being typed counts toward the limit
    assign room = opnd_cnt < CNT_W'(`CALC_MAX_OPERANDS - 1);

    always_comb
    begin
        mem.req  = num_pend || op_pend;
        mem.we   = 1'b1;
        mem.addr = wr_ptr;
        if (num_pend)
            mem.wdata = '{kind: TOK_NUM, op: OP_ADD, value: num_val};
        else
            mem.wdata = '{kind: TOK_OP, op: op_val, value: '0};
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            mag         <= '0;
            neg         <= 1'b0;
            have_digit  <= 1'b0;
            opnd_cnt    <= '0;
            wr_ptr      <= '0;
            num_pend    <= 1'b0;
            op_pend     <= 1'b0;
            eq_pend     <= 1'b0;
            busy_q      <= 1'b0;
            expr_start  <= 1'b0;
            infix_count <= '0;
        end
        else
        begin
            expr_start <= 1'b0;
            if (eval_done)
                busy_q <= 1'b0;

            // operand goes out before its operator
            if (mem.gnt)
            begin
                if (num_pend)
                begin
                    num_pend <= 1'b0;
                    if (eq_pend)
                    begin
                        eq_pend     <= 1'b0;
                        expr_start  <= 1'b1;
                        infix_count <= wr_ptr + 1'b1;
                        wr_ptr      <= '0;
                        opnd_cnt    <= '0;
                    end
                    else
                    begin
                        wr_ptr   <= wr_ptr + 1'b1;
                        opnd_cnt <= opnd_cnt + 1'b1;
                    end
                end
                else
                begin
                    op_pend <= 1'b0;
                    wr_ptr  <= wr_ptr + 1'b1;
                end
            end

            if (accept)
            begin
                case (key_code)
                    KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                    KEY_5, KEY_6, KEY_7, KEY_8, KEY_9:
                    begin
                        mag        <= mag * 10 + word_t'(key_code[3:0]); // wraps
                        have_digit <= 1'b1;
                    end
                    KEY_ADD, KEY_SUB, KEY_MUL:
                        if (have_digit && room)
                        begin
                            num_pend   <= 1'b1;
                            op_pend    <= 1'b1;
                            mag        <= '0;
                            neg        <= 1'b0;
                            have_digit <= 1'b0;
                        end
                    KEY_NEG:
                        neg <= !neg;
                    KEY_EQU:
                        if (have_digit)
                        begin
                            num_pend   <= 1'b1;
                            eq_pend    <= 1'b1;
                            busy_q     <= 1'b1;
                            mag        <= '0;
                            neg        <= 1'b0;
                            have_digit <= 1'b0;
                        end
                    KEY_CLR:
                    begin
                        mag        <= '0;
                        neg        <= 1'b0;
                        have_digit <= 1'b0;
                        wr_ptr     <= '0;
                        opnd_cnt   <= '0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // token payload, held while a write is pending
    always_ff @(posedge rst)
    begin
        if (accept)
        begin
            num_val <= neg ? -mag : mag;
            case (key_code)
                KEY_SUB: op_val <= OP_SUB;
                KEY_MUL: op_val <= OP_MUL;
                default: op_val <= OP_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/infix_to_postfix.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

module infix_to_postfix
    import calc_pkg::*;
(
    input  wire logic                    rst,
    input  wire logic                    clk_100hz,
    input  wire logic                    expr_start,
    input  wire logic [`CALC_ADDR_W-1:0] infix_count,
    token_mem_if.client                  mem,
    output logic [`CALC_ADDR_W-1:0]      postfix_count,
    output logic                         conv_done
);

    localparam int IDX_W = $clog2(`CALC_STACK_DEPTH);
    localparam int SP_W  = $clog2(`CALC_STACK_DEPTH + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_WAIT,
        S_PLACE,
        S_DRAIN
    } conv_state_e;

    conv_state_e             state;
    logic [`CALC_ADDR_W-1:0] rd_idx;
    logic [SP_W-1:0]         sp;
    opcode_e                 stk [0:`CALC_STACK_DEPTH-1];
    opcode_e                 top_op;
    token_t                  cur;
    logic                    pop_now;
    logic                    push_now;

    function automatic logic rank(input opcode_e op);
        return op == OP_MUL;
    endfunction

    assign top_op = stk[IDX_W'(sp - 1'b1)];

    // equal or higher rank on top leaves first, keeps left associativity
    assign pop_now = (sp != '0) &&
                     ((state == S_DRAIN) ||
                      (state == S_PLACE && cur.kind == TOK_OP && rank(top_op) >= rank(cur.op)));

    assign push_now = state == S_PLACE && cur.kind == TOK_OP && !pop_now;

    always_comb
    begin
        mem.req   = 1'b0;
        mem.we    = 1'b0;
        mem.addr  = rd_idx;
        mem.wdata = cur;
        if (state == S_READ)
            mem.req = rd_idx != infix_count;
        else if (pop_now)
        begin
            mem.req   = 1'b1;
            mem.we    = 1'b1;
            mem.addr  = `CALC_ADDR_W'(`CALC_POSTFIX_BASE) + postfix_count;
            mem.wdata = '{kind: TOK_OP, op: top_op, value: '0};
        end
        else if (state == S_PLACE && cur.kind == TOK_NUM)
        begin
            mem.req  = 1'b1;  // numbers pass straight through
            mem.we   = 1'b1;
            mem.addr = `CALC_ADDR_W'(`CALC_POSTFIX_BASE) + postfix_count;
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state         <= S_IDLE;
            rd_idx        <= '0;
            sp            <= '0;
            postfix_count <= '0;
            conv_done     <= 1'b0;
        end
        else
        begin
            conv_done <= 1'b0;
            case (state)
                S_IDLE:
                    if (expr_start)
                    begin
                        rd_idx        <= '0;
                        sp            <= '0;
                        postfix_count <= '0;
                        state         <= S_READ;
                    end
                S_READ:
                    if (rd_idx == infix_count)
                        state <= S_DRAIN;
                    else if (mem.gnt)
                    begin
                        rd_idx <= rd_idx + 1'b1;
                        state  <= S_WAIT;
                    end
                S_WAIT:
                    state <= S_PLACE;
                S_PLACE:
                    if (pop_now)
                    begin
                        if (mem.gnt)
                        begin
                            sp            <= sp - 1'b1;
                            postfix_count <= postfix_count + 1'b1;
                        end
                    end
                    else if (push_now)
                    begin
                        sp    <= sp + 1'b1;
                        state <= S_READ;
                    end
                    else if (mem.gnt)
                    begin
                        postfix_count <= postfix_count + 1'b1;
                        state         <= S_READ;
                    end
                S_DRAIN:
                    if (sp == '0)
                    begin
                        conv_done <= 1'b1;
                        state     <= S_IDLE;
                    end
                    else if (mem.gnt)
                    begin
                        sp            <= sp - 1'b1;
                        postfix_count <= postfix_count + 1'b1;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (state == S_WAIT)
            cur <= mem.rdata;
        if (push_now)
            stk[IDX_W'(sp)] <= cur.op;
    end

endmodule

`default_nettype wire

// File: source/postfix_eval.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

module postfix_eval
    import calc_pkg::*;
(
    input  wire logic                    rst,
    input  wire logic                    clk_100hz,
    input  wire logic                    expr_start,
    input  wire logic [`CALC_ADDR_W-1:0] postfix_count,
    input  wire logic                    conv_done,
    token_mem_if.client                  mem,
    output logic                         eval_done,
    output logic                         result_valid,
    output word_t                        result
);

    localparam int IDX_W = $clog2(`CALC_STACK_DEPTH);
    localparam int SP_W  = $clog2(`CALC_STACK_DEPTH + 1);

    typedef enum logic [1:0] {
        EV_IDLE,
        EV_FETCH,
        EV_EXEC
    } eval_state_e;

    eval_state_e             state;
    logic [`CALC_ADDR_W-1:0] rd_idx;
    logic [SP_W-1:0]         vsp;
    word_t                   vstk [0:`CALC_STACK_DEPTH-1];
    logic                    conv_seen;
    logic                    finish;
    word_t                   lhs;
    word_t                   rhs;
    word_t                   alu;

    // runs behind the converter, never past what it has written
    assign finish = state == EV_FETCH && rd_idx == postfix_count && (conv_seen || conv_done);

    always_comb
    begin
        mem.req   = state == EV_FETCH && rd_idx != postfix_count;
        mem.we    = 1'b0;
        mem.addr  = `CALC_ADDR_W'(`CALC_POSTFIX_BASE) + rd_idx;
        mem.wdata = '0;
    end

    always_comb
    begin
        lhs = vstk[IDX_W'(vsp - 2'd2)]; // second popped
        rhs = vstk[IDX_W'(vsp - 1'b1)]; // first popped
        case (mem.rdata.op)
            OP_SUB:  alu = lhs - rhs;
            OP_MUL:  alu = lhs * rhs;   // low word only
            default: alu = lhs + rhs;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state        <= EV_IDLE;
            rd_idx       <= '0;
            vsp          <= '0;
            conv_seen    <= 1'b0;
            eval_done    <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
        end
        else
        begin
            eval_done    <= 1'b0;
            result_valid <= 1'b0;
            if (conv_done)
                conv_seen <= 1'b1;
            case (state)
                EV_IDLE:
                    if (expr_start)
                    begin
                        rd_idx    <= '0;
                        vsp       <= '0;
                        conv_seen <= 1'b0;
                        state     <= EV_FETCH;
                    end
                EV_FETCH:
                    if (finish)
                    begin
                        result       <= vstk[0];
                        result_valid <= 1'b1;
                        eval_done    <= 1'b1;
                        state        <= EV_IDLE;
                    end
                    else if (mem.gnt)
                    begin
                        rd_idx <= rd_idx + 1'b1;
                        state  <= EV_EXEC;
                    end
                EV_EXEC:
                begin
                    if (mem.rdata.kind == TOK_NUM)
                        vsp <= vsp + 1'b1;
                    else
                        vsp <= vsp - 1'b1;
                    state <= EV_FETCH;
                end
                default:
                    state <= EV_IDLE;
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (state == EV_EXEC)
        begin
            if (mem.rdata.kind == TOK_NUM)
                vstk[IDX_W'(vsp)] <= mem.rdata.value;
            else
                vstk[IDX_W'(vsp - 2'd2)] <= alu;
        end
    end

endmodule

`default_nettype wire

// File: source/calc_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "calc_defines.svh"

module calc_top
    import calc_pkg::*;
(
    input  wire logic rst,
    input  wire logic clk_100hz,
    input  wire logic key_valid,
    input  wire key_e key_code,
    output logic      busy,
    output logic      result_valid,
    output word_t     result
);

    token_mem_if ent_mem ();
    token_mem_if cnv_mem ();
    token_mem_if evl_mem ();

    logic                    expr_start;
    logic [`CALC_ADDR_W-1:0] infix_count;
    logic [`CALC_ADDR_W-1:0] postfix_count;
    logic                    conv_done;
    logic                    eval_done;

    token_arbiter arb_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .ent       (ent_mem.arbiter),
        .cnv       (cnv_mem.arbiter),
        .evl       (evl_mem.arbiter)
    );

    expr_entry entry_i (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .eval_done   (eval_done),
        .mem         (ent_mem.client),
        .expr_start  (expr_start),
        .infix_count (infix_count),
        .busy        (busy)
    );

    infix_to_postfix conv_i (
        .rst           (rst),
        .clk_100hz     (clk_100hz),
        .expr_start    (expr_start),
        .infix_count   (infix_count),
        .mem           (cnv_mem.client),
        .postfix_count (postfix_count),
        .conv_done     (conv_done)
    );

    postfix_eval eval_i (
        .rst           (rst),
        .clk_100hz     (clk_100hz),
        .expr_start    (expr_start),
        .postfix_count (postfix_count),
        .conv_done     (conv_done),
        .mem           (evl_mem.client),
        .eval_done     (eval_done),
        .result_valid  (result_valid),
        .result        (result)
    );

endmodule

`default_nettype wire

// File: sim/tb_calc.sv
`default_nettype none
`timescale 1ns/1ps

module tb_calc
    import calc_pkg::*;
;
    localparam int RESULT_TIMEOUT = 400;
    localparam int BUSY_TIMEOUT   = 50;

    logic  rst;        // clock
    logic  clk_100hz;  // reset
    logic  key_valid;
    key_e  key_code;
    logic  busy;
    logic  result_valid;
    word_t result;

    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          rv_count;
    word_t       rv_value;
    logic        aborted;
    logic        busy_prev;
    logic [31:0] rng_state;

    calc_top dut_i (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    always #5 rst = ~rst;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic char_to_key(input logic [7:0] ch, output key_e k);
        k = KEY_0;
        char_to_key = 1'b1;
        case (ch)
            "+": k = KEY_ADD;
            "-": k = KEY_SUB;
            "x": k = KEY_MUL;
            "n": k = KEY_NEG;
            "c": k = KEY_CLR;
            "=": k = KEY_EQU;
            default:
                if (ch >= "0" && ch <= "9")
                    k = key_e'(5'(ch - 8'd48));
                else
                    char_to_key = 1'b0;
        endcase
    endfunction

    task automatic check_result(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic press_key(input key_e k);
        key_valid = 1'b1;
        key_code  = k;
        @(negedge rst);
        key_valid = 1'b0;
    endtask

    // record each result pulse
    always @(negedge rst)
    begin
        if (result_valid === 1'b1)
        begin
            rv_value = result;
            rv_count++;
            check_flag("busy", busy, 1'b0);
            check_flag("busy_prev", busy_prev, 1'b1); // still high one cycle before
        end
        busy_prev = busy;
    end

    task automatic run_test(input string tname, input string keys, input word_t exp_val);
        int          start_cnt;
        int          start_err;
        int          i;
        int          n;
        int          gap;
        int          last_eq;
        logic [7:0]  ch;
        key_e        k;
        start_cnt = rv_count;
        start_err = err_cnt;
        last_eq   = -1;
        for (i = 0; i < keys.len(); i++)
        begin
            if (keys[i] == "=")
                last_eq = i;
        end
        for (i = 0; i < keys.len(); i++)
        begin
            ch = keys[i];
            if (ch == "b")
            begin
                check_flag("busy", busy, 1'b1); // key must land while busy
                press_key(KEY_5);
            end
            else if (char_to_key(ch, k))
            begin
                if (i == last_eq)
                    check_flag("busy", busy, 1'b0);
                press_key(k);
                if (i == last_eq)
                    check_flag("busy", busy, 1'b1); // up right after the final equals
            end
            else
            begin
                $display("test %s has an unknown key character '%c'", tname, ch);
                err_cnt++;
            end
            if (i + 1 < keys.len() && keys[i + 1] == "b")
                gap = 4;
            else
            begin
                rng_state = xorshift32(rng_state);
                gap = 4 + int'(rng_state % 8);
            end
            repeat (gap) @(negedge rst);
        end

        n = 0;
        while (rv_count == start_cnt && n < RESULT_TIMEOUT)
        begin
            @(negedge rst);
            n++;
        end
        if (rv_count == start_cnt)
        begin
            $display("timeout in test %s, result_valid never came", tname);
            err_cnt++;
            aborted = 1'b1;
        end
        else
        begin
            n = 0;
            while (busy && n < BUSY_TIMEOUT)
            begin
                @(negedge rst);
                n++;
            end
            if (busy)
            begin
                $display("timeout in test %s, busy stayed high", tname);
                err_cnt++;
                aborted = 1'b1;
            end
            else
            begin
                repeat (2) @(negedge rst);
                check_result("result", rv_value, exp_val);
                check_result("result", result, exp_val); // held after the pulse
                check_flag("result_valid", result_valid, 1'b0);
                if (rv_count != start_cnt + 1)
                begin
                    $display("test %s saw %0d result pulses instead of one",
                             tname, rv_count - start_cnt);
                    err_cnt++;
                end
            end
        end

        if (err_cnt == start_err)
        begin
            pass_cnt++;
            $display("done %-18s ok    result=%0d", tname, rv_value);
        end
        else
        begin
            fail_cnt++;
            $display("done %-18s wrong expected=%0d", tname, exp_val);
        end
    endtask

    initial
    begin
        int     fd;
        int     code;
        integer exp_i;
        string  line;
        string  tname;
        string  keys;
        rst       = 1'b0;
        clk_100hz = 1'b1;
        key_valid = 1'b0;
        key_code  = KEY_0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        rv_count  = 0;
        rv_value  = '0;
        aborted   = 1'b0;
        busy_prev = 1'b0;
        rng_state = 32'h638b881c;

        repeat (16) @(negedge rst);
        clk_100hz = 1'b0;
        @(negedge rst);

        code = err_cnt;
        check_flag("busy", busy, 1'b0);
        check_flag("result_valid", result_valid, 1'b0);
        check_result("result", result, '0);
        if (err_cnt == code)
        begin
            pass_cnt++;
            $display("done %-18s ok", "reset");
        end
        else
        begin
            fail_cnt++;
            $display("done %-18s wrong", "reset");
        end

        fd = $fopen("sim/calc_golden.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the golden file sim/calc_golden.txt");
            aborted = 1'b1;
        end
        else
        begin
            while (!aborted && !$feof(fd))
            begin
                line = "";
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 1 && line[0] != "#")
                begin
                    if ($sscanf(line, "%s %s %d", tname, keys, exp_i) == 3)
                        run_test(tname, keys, word_t'(exp_i));
                    else
                    begin
                        $display("golden line could not be parsed: %s", line);
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && !aborted && pass_cnt > 1)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/calc_pkg.sv
source/token_mem_if.sv
source/token_arbiter.sv
source/expr_entry.sv
source/infix_to_postfix.sv
source/postfix_eval.sv
source/calc_top.sv
sim/tb_calc.sv

// File: sim/calc_golden.txt
# columns: test name, key string, expected result in signed decimal
# keys: 0-9 digits, + - x operators, n negate, c clear, = equals, b digit while busy
sum_diff          12-5+30=              37
multi_digit       250+750-1=            999
prec_mul_add      2+3x4-5=              9
left_assoc_sub    8-2-1=                5
prec_two_products 2x3+4x5=              26
prec_chain        100-2x3x4=            76
mul_chain         1+2x3x4+5=            30
neg_operand       n7x3+4=               -17
double_neg        nn5-8=                -3
sub_negative      3-n2=                 5
wrap_product      100000x100000=        1410065408
wrap_neg_product  n99999x99999=         -1409865409
wrap_entry        4294967297+0=         1
busy_keys         2x3x4+5=bb            29
after_busy        7=                    7
clear_partial     45+6c7x8=             56
double_operator   9+x2=                 11
equals_no_digit   5+=3=                 8
max_operands      1+1+1+1+1+1+1+1+23=   130
